// File: sim.f
common/dsp_pkg.sv
common/cmd_bus_if.sv
sequencer/pulse_timer.sv
sequencer/seq_fsm.sv
hdl/cmd_mem.sv
hdl/env_mem.sv
hdl/pulse_element.sv
hdl/dsp_unit.sv
verif/dsp_unit_sva.sv
verif/dsp_unit_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the dsp_unit testbench with Verilator, runs it and checks the log

set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module dsp_unit_tb -f sim.f \
    --Mdir obj_dir -o dsp_unit_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/dsp_unit_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "simulation exited with an error, see sim.log"
    exit 1
fi

if grep -q "^Testbench passed$" sim.log; then
    echo "simulation result: pass"
    exit 0
else
    echo "simulation result: fail, see sim.log"
    exit 1
fi

// File: verif/dsp_unit_tb.sv
// self-checking testbench that loads envelope and command programs into dsp_unit and checks each DAC sample
`timescale 1ns/100ps
`default_nettype none

module dsp_unit_tb;

    typedef struct packed {
        logic [1:0]  op;
        logic [23:0] start;
        logic [13:0] freq;
        logic [13:0] phase;
        logic [9:0]  addr;
        logic [9:0]  len;
    } entry_t;

    localparam int N_ENTRIES = 11;
    localparam int N_PROGS   = 2;

    // op, start time, frequency, initial phase, envelope address, length
    entry_t entries [N_ENTRIES] = '{
        '{2'b01,  20,     0,     0,   10,  6},
        '{2'b01,   0,  4096,     0,  100,  8},
        '{2'b00,   0,     0,     0,    0,  5},
        '{2'b01,   0,     0,  5000, 1020,  7},
        '{2'b01, 200,     0,     0,    0,  0},
        '{2'b01, 210,  3000, 12000,  500, 12},
        '{2'b10,   0,     0,     0,    0,  0},
        '{2'b01,   5,     7,  8191, 1023,  3},
        '{2'b11,   0,     0,     0,    0,  4},
        '{2'b01,   0, 12288,  2048,    0,  5},
        '{2'b10,   0,     0,     0,    0,  0}
    };
    // each program is a run of entries that is loaded from buffer address 0
    int prog_base [N_PROGS] = '{0, 7};
    int prog_size [N_PROGS] = '{7, 4};

    logic        clk;
    logic        reset;
    logic        start;
    logic [12:0] mem_write_addr;
    logic [31:0] mem_write_data;
    logic        mem_write_en;
    logic [15:0] dac_i;
    logic [15:0] dac_q;
    logic        dac_valid;
    logic        done;

    logic [15:0] env_i_m [1024];
    logic [15:0] env_q_m [1024];
    logic [15:0] exp_i [$];
    logic [15:0] exp_q [$];
    int          exp_k [$];
    int          exp_t [$];
    bit          exp_first [$];
    logic [15:0] got_i [$];
    logic [15:0] got_q [$];
    int          got_cyc [$];
    time         got_time [$];
    int          cyc = 0;
    int          start_cyc;
    int          seed;
    int          value_errs;
    int          other_errs;
    int          assert_errs;

    dsp_unit i_dut (
        .clk            (clk),
        .reset          (reset),
        .start          (start),
        .mem_write_addr (mem_write_addr),
        .mem_write_data (mem_write_data),
        .mem_write_en   (mem_write_en),
        .dac_i          (dac_i),
        .dac_q          (dac_q),
        .dac_valid      (dac_valid),
        .done           (done)
    );

    bind dsp_unit dsp_unit_sva i_dsp_unit_sva (
        .clk       (clk),
        .reset     (reset),
        .cstrobe   (cmd_bus.cstrobe),
        .busy      (cmd_bus.busy),
        .dac_valid (dac_valid),
        .done      (done),
        .dac_i     (dac_i),
        .dac_q     (dac_q)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // outputs are sampled mid-cycle, well away from the rising edge
    always @(negedge clk) begin
        if (dac_valid === 1'b1) begin
            got_i.push_back(dac_i);
            got_q.push_back(dac_q);
            got_cyc.push_back(cyc);
            got_time.push_back($time);
        end
    end

    task automatic host_write(input logic [12:0] addr, input logic [31:0] data);
        @(posedge clk);
        #0.5;
        mem_write_addr = addr;
        mem_write_data = data;
        mem_write_en   = 1'b1;
    endtask

    task automatic host_idle();
        @(posedge clk);
        #0.5;
        mem_write_en = 1'b0;
    endtask

    task automatic fill_envelope();
        logic [31:0] w;
        for (int a = 0; a < 1024; a++) begin
            w = $random(seed);
            env_i_m[a] = w[15:0];
            env_q_m[a] = w[31:16];
            host_write({3'b100, 10'(a)}, w);
        end
        host_idle();
    endtask

    task automatic load_program(input int p);
        entry_t e;
        for (int n = 0; n < prog_size[p]; n++) begin
            e = entries[prog_base[p] + n];
            host_write({5'b00000, 8'(n)}, {e.op, 6'b0, e.start});
            host_write({5'b00001, 8'(n)}, {18'b0, e.freq});
            host_write({5'b00010, 8'(n)}, {18'b0, e.phase});
            host_write({5'b00011, 8'(n)}, {6'b0, e.len, 6'b0, e.addr});
        end
        host_idle();
    endtask

    // the quadrant of the running phase picks one of four exact rotations
    function automatic void build_expected(input int p);
        entry_t      e;
        int          ph;
        int          a;
        logic [15:0] ei;
        logic [15:0] eq;
        for (int n = 0; n < prog_size[p]; n++) begin
            e = entries[prog_base[p] + n];
            if (e.op == 2'b01) begin
                for (int k = 0; k < int'(e.len); k++) begin
                    ph = (int'(e.phase) + k * int'(e.freq)) % 16384;
                    a  = (int'(e.addr) + k) % 1024;
                    case (ph / 4096)
                        0: begin
                            ei = env_i_m[a];
                            eq = env_q_m[a];
                        end
                        1: begin
                            ei = -env_q_m[a];
                            eq = env_i_m[a];
                        end
                        2: begin
                            ei = -env_i_m[a];
                            eq = -env_q_m[a];
                        end
                        default: begin
                            ei = env_q_m[a];
                            eq = -env_i_m[a];
                        end
                    endcase
                    exp_i.push_back(ei);
                    exp_q.push_back(eq);
                    exp_k.push_back(k);
                    exp_t.push_back(int'(e.start));
                    exp_first.push_back(n == 0 && k == 0 && e.start >= 3);
                end
            end
        end
    endfunction

    function automatic int prog_budget(input int p);
        entry_t e;
        int     latest;
        int     total;
        latest = 0;
        total  = 0;
        for (int n = 0; n < prog_size[p]; n++) begin
            e = entries[prog_base[p] + n];
            if (int'(e.start) > latest) begin
                latest = int'(e.start);
            end
            total += int'(e.len);
        end
        return latest + total + 20 * prog_size[p] + 50;
    endfunction

    task automatic check_results(input int p);
        int n;
        int rel;
        int prev_rel;
        n = (got_i.size() < exp_i.size()) ? got_i.size() : exp_i.size();
        if (got_i.size() != exp_i.size()) begin
            other_errs++;
            $display("program %0d gave %0d valid samples but %0d were expected",
                     p, got_i.size(), exp_i.size());
        end
        for (int j = 0; j < n; j++) begin
            rel = got_cyc[j] - start_cyc;
            if (got_i[j] !== exp_i[j] || got_q[j] !== exp_q[j]) begin
                value_errs++;
                $display("error at %0d ns: program %0d sample %0d expected (%0d, %0d) got (%0d, %0d)",
                         got_time[j], p, j, $signed(exp_i[j]), $signed(exp_q[j]),
                         $signed(got_i[j]), $signed(got_q[j]));
            end
            if (exp_first[j] && rel != exp_t[j] + 4) begin
                value_errs++;
                $display("error at %0d ns: first sample came %0d cycles after start, expected %0d",
                         got_time[j], rel, exp_t[j] + 4);
            end
            if (exp_k[j] == 0 && rel < exp_t[j] + 4) begin
                other_errs++;
                $display("sample %0d of program %0d played before its start time", j, p);
            end
            if (exp_k[j] > 0 && got_cyc[j] != got_cyc[j-1] + 1) begin
                other_errs++;
                $display("a pulse had a gap before sample %0d of program %0d", j, p);
            end
            if (exp_k[j] == 0 && j > 0) begin
                prev_rel = got_cyc[j-1] - start_cyc;
                // a pulse whose time has passed should follow the previous one closely
                if (exp_t[j] + 4 <= prev_rel && rel - prev_rel > 16) begin
                    other_errs++;
                    $display("late pulse at sample %0d of program %0d did not fire at once", j, p);
                end
            end
        end
    endtask

    task automatic run_program(input int p);
        int waited;
        load_program(p);
        exp_i.delete();
        exp_q.delete();
        exp_k.delete();
        exp_t.delete();
        exp_first.delete();
        got_i.delete();
        got_q.delete();
        got_cyc.delete();
        got_time.delete();
        build_expected(p);
        @(posedge clk);
        #0.5;
        start     = 1'b1;
        start_cyc = cyc;
        @(posedge clk);
        #0.5;
        start = 1'b0;
        if (done !== 1'b0) begin
            other_errs++;
            $display("done stayed high after the start of program %0d", p);
        end
        waited = 0;
        while (done !== 1'b1 && waited < prog_budget(p)) begin
            @(posedge clk);
            #0.5;
            waited++;
        end
        if (done !== 1'b1) begin
            other_errs++;
            $display("program %0d never raised done", p);
        end else begin
            repeat (4) begin
                @(posedge clk);
                #0.5;
                if (done !== 1'b1) begin
                    other_errs++;
                    $display("done dropped before a new start in program %0d", p);
                end
            end
        end
        check_results(p);
    endtask

    initial begin
        int limit;
        limit = 1100;
        for (int p = 0; p < N_PROGS; p++) begin
            limit += 4 * prog_size[p] + 10 + prog_budget(p);
        end
        repeat (limit) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", limit);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        clk            = 1'b0;
        reset          = 1'b1;
        start          = 1'b0;
        mem_write_addr = '0;
        mem_write_data = '0;
        mem_write_en   = 1'b0;
        seed           = 32'hda98_b7c2;
        value_errs     = 0;
        other_errs     = 0;
        assert_errs    = 0;
        repeat (2) @(posedge clk);
        #0.5;
        reset = 1'b0;
        fill_envelope();
        for (int p = 0; p < N_PROGS; p++) begin
            run_program(p);
        end
        assert_errs = i_dut.i_dsp_unit_sva.fail_count;
        $display("error counts: %0d value errors, %0d other errors, %0d assertion failures",
                 value_errs, other_errs, assert_errs);
        if (value_errs == 0 && other_errs == 0 && assert_errs == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/dsp_unit_sva.sv
// assertions bound into dsp_unit that watch the command strobe, the sample valid and done
`timescale 1ns/100ps
`default_nettype none

module dsp_unit_sva import dsp_pkg::*; (
    input logic    clk,
    input logic    reset,
    input logic    cstrobe,
    input logic    busy,
    input logic    dac_valid,
    input logic    done,
    input sample_t dac_i,
    input sample_t dac_q
);

    // number of assertion failures seen so far
    int fail_count = 0;

    // fetch and decode always sit between two strobes
    strobe_single: assert property (@(posedge clk) disable iff (reset) cstrobe |=> !cstrobe)
        else begin
            fail_count++;
            $error("cstrobe high for two consecutive cycles");
        end

    valid_not_done: assert property (@(posedge clk) disable iff (reset) !(dac_valid && done))
        else begin
            fail_count++;
            $error("dac_valid high while done is high");
        end

    // reset is synchronous so the outputs read 0 from the edge after it is seen
    reset_clears: assert property (@(posedge clk)
        reset |=> (!cstrobe && !busy && !dac_valid && !done && dac_i == '0 && dac_q == '0))
        else begin
            fail_count++;
            $error("outputs not cleared while reset is high");
        end

endmodule

`default_nettype wire

// File: hdl/dsp_unit.sv
// top level of one DAC I/Q channel, host write port in, rotated envelope samples out
`timescale 1ns/100ps
`default_nettype none

module dsp_unit import dsp_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       start,
    input  mem_addr_t  mem_write_addr,
    input  data_word_t mem_write_data,
    input  logic       mem_write_en,
    output sample_t    dac_i,
    output sample_t    dac_q,
    output logic       dac_valid,
    output logic       done
);

    logic      timer_clear;
    logic      time_reached;
    tref_t     start_time;
    env_addr_t env_raddr;
    sample_t   env_i;
    sample_t   env_q;

    cmd_bus_if cmd_bus ();

    // the host write port goes to both memories, bit 12 sorts it out
    cmd_mem i_cmd_mem (
        .clk            (clk),
        .mem_write_addr (mem_write_addr),
        .mem_write_data (mem_write_data),
        .mem_write_en   (mem_write_en),
        .bus            (cmd_bus.mem)
    );

    env_mem i_env_mem (
        .clk            (clk),
        .mem_write_addr (mem_write_addr),
        .mem_write_data (mem_write_data),
        .mem_write_en   (mem_write_en),
        .read_addr      (env_raddr),
        .read_i         (env_i),
        .read_q         (env_q)
    );

    seq_fsm i_seq_fsm (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .time_reached (time_reached),
        .timer_clear  (timer_clear),
        .start_time   (start_time),
        .done         (done),
        .bus          (cmd_bus.seq)
    );

    pulse_timer i_pulse_timer (
        .clk          (clk),
        .reset        (reset),
        .timer_clear  (timer_clear),
        .start_time   (start_time),
        .time_reached (time_reached)
    );

    pulse_element i_pulse_element (
        .clk       (clk),
        .reset     (reset),
        .bus       (cmd_bus.elem),
        .env_raddr (env_raddr),
        .env_i     (env_i),
        .env_q     (env_q),
        .dac_i     (dac_i),
        .dac_q     (dac_q),
        .dac_valid (dac_valid)
    );

endmodule

`default_nettype wire

// File: hdl/pulse_element.sv
// pulse player, steps through the envelope and rotates each sample by the phase quadrant
`timescale 1ns/100ps
`default_nettype none

module pulse_element import dsp_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    cmd_bus_if.elem    bus,
    output env_addr_t  env_raddr,
    input  sample_t    env_i,
    input  sample_t    env_q,
    output sample_t    dac_i,
    output sample_t    dac_q,
    output logic       dac_valid
);

    phase_t              freq_q;
    phase_t              phase_acc;
    env_addr_t           addr_q;
    env_addr_t           count_q;
    logic                issuing;
    logic [QUAD_W-1:0]   quad_d;
    logic                valid_d;
    sample_t             rot_i;
    sample_t             rot_q;

    // one sample address goes out per cycle while samples remain
    assign issuing   = (count_q != '0);
    assign env_raddr = addr_q;
    assign bus.busy  = issuing || valid_d || dac_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            count_q <= '0;
            valid_d <= 1'b0;
        end else begin
            if (bus.cstrobe) begin
                count_q <= bus.cmd[ENV_LEN_LSB +: ENV_ADDR_W];
            end else if (issuing) begin
                count_q <= count_q - 1'b1;
            end
            valid_d <= issuing;
        end
    end

    // address and phase wrap naturally at their widths
    always_ff @(posedge clk) begin
        if (bus.cstrobe) begin
            freq_q    <= bus.cmd[FREQ_LSB +: PHASE_W];
            phase_acc <= bus.cmd[PHASE_LSB +: PHASE_W];
            addr_q    <= bus.cmd[ENV_ADDR_LSB +: ENV_ADDR_W];
        end else if (issuing) begin
            phase_acc <= phase_acc + freq_q;
            addr_q    <= addr_q + 1'b1;
        end
        // quadrant travels alongside the memory read
        quad_d <= phase_acc[PHASE_W-1 -: QUAD_W];
    end

    always_comb begin
        case (quad_d)
            2'd0: begin
                rot_i = env_i;
                rot_q = env_q;
            end
            2'd1: begin
                rot_i = -env_q;
                rot_q = env_i;
            end
            2'd2: begin
                rot_i = -env_i;
                rot_q = -env_q;
            end
            default: begin
                rot_i = env_q;
                rot_q = -env_i;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            dac_valid <= 1'b0;
            dac_i     <= '0;
            dac_q     <= '0;
        end else begin
            dac_valid <= valid_d;
            dac_i     <= rot_i;
            dac_q     <= rot_q;
        end
    end

endmodule

`default_nettype wire

// File: hdl/env_mem.sv
// envelope memory of I/Q sample pairs, written by the host and read by the pulse element
`timescale 1ns/100ps
`default_nettype none

module env_mem import dsp_pkg::*; (
    input  logic       clk,
    input  mem_addr_t  mem_write_addr,
    input  data_word_t mem_write_data,
    input  logic       mem_write_en,
    input  env_addr_t  read_addr,
    output sample_t    read_i,
    output sample_t    read_q
);

    data_word_t ram [ENV_DEPTH];
    data_word_t rd_q;
    logic       write_hit;

    assign write_hit = mem_write_en && mem_write_addr[MEM_SEL_BIT];

    always_ff @(posedge clk) begin
        if (write_hit) begin
            ram[mem_write_addr[ENV_ADDR_W-1:0]] <= mem_write_data;
        end
        rd_q <= ram[read_addr];
    end

    // I in the low half, Q in the high half
    assign read_i = rd_q[SAMPLE_W-1:0];
    assign read_q = rd_q[DATA_W-1:SAMPLE_W];

endmodule

`default_nettype wire

// File: hdl/cmd_mem.sv
// command buffer of four 32-bit banks, written by the host and read as one 128-bit command
`timescale 1ns/100ps
`default_nettype none

module cmd_mem import dsp_pkg::*; (
    input  logic       clk,
    input  mem_addr_t  mem_write_addr,
    input  data_word_t mem_write_data,
    input  logic       mem_write_en,
    cmd_bus_if.mem     bus
);

    data_word_t                         ram [N_BANKS][CMD_DEPTH];
    logic [N_BANKS-1:0][DATA_W-1:0]     rd_q;
    logic [N_BANKS-1:0]                 bank_we;
    logic [BANK_W-1:0]                  bank_sel;
    cmd_addr_t                          write_ptr;

    assign bank_sel  = mem_write_addr[BANK_LSB +: BANK_W];
    assign write_ptr = mem_write_addr[CMD_ADDR_W-1:0];

    // bit 12 low addresses the command buffer
    always_comb begin
        for (int b = 0; b < N_BANKS; b++) begin
            bank_we[b] = mem_write_en && !mem_write_addr[MEM_SEL_BIT]
                         && (bank_sel == BANK_W'(b));
        end
    end

    always_ff @(posedge clk) begin
        for (int b = 0; b < N_BANKS; b++) begin
            if (bank_we[b]) begin
                ram[b][write_ptr] <= mem_write_data;
            end
            rd_q[b] <= ram[b][bus.instr_ptr];
        end
    end

    // bank 0 ends up in the low word
    assign bus.cmd = rd_q;

endmodule

`default_nettype wire

// File: sequencer/seq_fsm.sv
// command sequencer FSM, fetches commands, waits for their start time and strobes the pulse element
`timescale 1ns/100ps
`default_nettype none

module seq_fsm import dsp_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       start,
    input  logic       time_reached,
    output logic       timer_clear,
    output tref_t      start_time,
    output logic       done,
    cmd_bus_if.seq     bus
);

    seq_state_t                state;
    seq_state_t                state_next;
    cmd_addr_t                 instr_ptr;
    logic                      accept_start;
    logic                      ptr_step;
    logic [OPCODE_W-1:0]       opcode;

    // a start is only taken when no program is running
    assign accept_start = start && (state == ST_IDLE || state == ST_DONE);
    assign timer_clear  = accept_start;

    assign opcode     = bus.cmd[OPCODE_LSB +: OPCODE_W];
    assign start_time = bus.cmd[START_LSB +: TREF_W];

    assign bus.instr_ptr = instr_ptr;
    assign bus.cstrobe   = (state == ST_FIRE);
    assign done          = (state == ST_DONE);

    always_comb begin
        state_next = state;
        ptr_step   = 1'b0;
        case (state)
            ST_IDLE, ST_DONE: begin
                if (accept_start) begin
                    state_next = ST_FETCH;
                end
            end
            ST_FETCH: state_next = ST_DECODE;
            ST_DECODE: begin
                if (opcode == OP_PULSE) begin
                    state_next = ST_WAIT;
                end else if (opcode == OP_END) begin
                    // hold off done until the last pulse has left the pipeline
                    if (!bus.busy) begin
                        state_next = ST_DONE;
                    end
                end else begin
                    state_next = ST_FETCH;
                    ptr_step   = 1'b1;
                end
            end
            ST_WAIT: begin
                if (time_reached && !bus.busy) begin
                    state_next = ST_FIRE;
                end
            end
            ST_FIRE: begin
                state_next = ST_FETCH;
                ptr_step   = 1'b1;
            end
            default: state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= ST_IDLE;
            instr_ptr <= '0;
        end else begin
            state <= state_next;
            if (accept_start) begin
                instr_ptr <= '0;
            end else if (ptr_step) begin
                instr_ptr <= instr_ptr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: sequencer/pulse_timer.sv
// time reference counter for the sequencer, compares the running time with a command's start time
`timescale 1ns/100ps
`default_nettype none

module pulse_timer import dsp_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  timer_clear,
    input  tref_t start_time,
    output logic  time_reached
);

    tref_t tref;
    tref_t tref_next;

    assign tref_next = tref + 1'b1;

    // the strobe lands one cycle after the FSM sees this, so compare against the
    // time of that strobe cycle
    assign time_reached = (tref_next >= start_time);

    always_ff @(posedge clk) begin
        if (reset) begin
            tref <= '0;
        end else if (timer_clear) begin
            // tref reads 0 in the first cycle after the start pulse
            tref <= '0;
        end else begin
            tref <= tref_next;
        end
    end

endmodule

`default_nettype wire

// File: common/cmd_bus_if.sv
// command bus shared by the command buffer, the sequencer and the pulse element
`timescale 1ns/100ps
`default_nettype none

interface cmd_bus_if import dsp_pkg::*; ();

    // instruction pointer into the four command banks
    cmd_addr_t instr_ptr;
    // 128-bit command, valid one cycle after instr_ptr changes
    cmd_word_t cmd;
    logic      cstrobe;
    // high while the element still has samples to issue or in flight
    logic      busy;

    modport seq (
        output instr_ptr,
        output cstrobe,
        input  cmd,
        input  busy
    );

    modport mem (
        input  instr_ptr,
        output cmd
    );

    modport elem (
        input  cmd,
        input  cstrobe,
        output busy
    );

endinterface

`default_nettype wire

// File: common/dsp_pkg.sv
// shared widths, command field positions, opcodes and sequencer states, imported by every RTL file
`default_nettype none

package dsp_pkg;

    localparam int DATA_W     = 32;
    localparam int MEM_ADDR_W = 13;
    localparam int CMD_ADDR_W = 8;
    localparam int N_BANKS    = 4;
    localparam int BANK_W     = 2;
    localparam int CMD_W      = DATA_W * N_BANKS;
    localparam int TREF_W     = 24;
    localparam int PHASE_W    = 14;
    localparam int QUAD_W     = 2;
    localparam int ENV_ADDR_W = 10;
    localparam int SAMPLE_W   = 16;
    localparam int CMD_DEPTH  = 1 << CMD_ADDR_W;
    localparam int ENV_DEPTH  = 1 << ENV_ADDR_W;

    // host address map, bit 12 picks the memory and bits 9:8 pick the command bank
    localparam int MEM_SEL_BIT = 12;
    localparam int BANK_LSB    = 8;

    // field positions inside the assembled command, bank 0 sits in bits 31:0
    localparam int OPCODE_LSB   = 30;
    localparam int OPCODE_W     = 2;
    localparam int START_LSB    = 0;
    localparam int FREQ_LSB     = 32;
    localparam int PHASE_LSB    = 64;
    localparam int ENV_ADDR_LSB = 96;
    localparam int ENV_LEN_LSB  = 112;

    // every other opcode value is a no-op
    localparam logic [OPCODE_W-1:0] OP_PULSE = 2'b01;
    localparam logic [OPCODE_W-1:0] OP_END   = 2'b10;

    typedef logic [DATA_W-1:0]            data_word_t;
    typedef logic [MEM_ADDR_W-1:0]        mem_addr_t;
    typedef logic [CMD_ADDR_W-1:0]        cmd_addr_t;
    typedef logic [CMD_W-1:0]             cmd_word_t;
    typedef logic [TREF_W-1:0]            tref_t;
    typedef logic [PHASE_W-1:0]           phase_t;
    typedef logic [ENV_ADDR_W-1:0]        env_addr_t;
    typedef logic signed [SAMPLE_W-1:0]   sample_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FETCH,
        ST_DECODE,
        ST_WAIT,
        ST_FIRE,
        ST_DONE
    } seq_state_t;

endpackage

`default_nettype wire
